// File: src.f
+incdir+include
hdl/dcache_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_line_state.sv
hdl/dcache_data_ram.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tests/dcache_assertions.sv
tests/dcache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module dcache_tb -f src.f -o dcache_sim
out=$(./obj_dir/dcache_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Finished with no errors"

// File: tests/dcache_tb.sv
// Testbench for the two-way data cache.
// Expected values come from a small model of the fill, write-back and age rules.
// Memory answers 1 to 4 cycles after a request; unwritten words read back
// as their word address XOR a fixed pattern.
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int    PERIOD       = 40;
    localparam int    NROWS        = 11;
    localparam word_t FILL_PATTERN = 64'hA5A5_5A5A_0F0F_F0F0;

    typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;

    typedef struct packed {
        logic  is_write;
        addr_t addr;
        word_t wdata;
        strb_t strb;
        logic  exp_hit;
        logic  exp_wb;
        addr_t exp_wb_addr;
        word_t exp_wb_data;
        word_t exp_rdata;
    } row_t;

    logic     clk;
    logic     reset_i;
    logic     req_valid_i;
    logic     req_write_i;
    addr_t    req_addr_i;
    word_t    req_wdata_i;
    strb_t    req_strb_i;
    logic     ready_o;
    word_t    rdata_o;
    mem_req_e mem_req_o;
    addr_t    mem_addr_o;
    word_t    mem_wdata_o;
    logic     mem_ready_i;
    word_t    mem_rdata_i;

    row_t     rows [NROWS];
    int       errors;
    int       wb_count;
    int       refill_count;
    addr_t    last_wb_addr;
    word_t    last_wb_data;
    addr_t    last_refill_addr;

    // reference model state and the two memory images
    tag_t     m_tag   [2][`DCACHE_SETS];
    word_t    m_data  [2][`DCACHE_SETS];
    bit       m_valid [2][`DCACHE_SETS];
    bit       m_dirty [2][`DCACHE_SETS];
    bit [2:0] m_age   [2][`DCACHE_SETS];
    word_t    model_mem [addr_t];
    word_t    bus_mem   [addr_t];

    dcache_top dcache_top_i (.*);

    bind dcache_ctrl dcache_assertions dcache_assertions_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .ready_o     (ready_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ready_i (mem_ready_i)
    );

    initial clk = 1'b0;
    always #(PERIOD/2) clk = ~clk;

    function automatic addr_t make_addr(input int tag, input int index, input int offset);
        return {tag_t'(tag), index_t'(index), offset_t'(offset)};
    endfunction

    function automatic word_t fill_value(input addr_t a);
        return word_t'(a) ^ FILL_PATTERN;
    endfunction

    function automatic word_t strb_mask(input strb_t s);
        word_t m;
        for (int b = 0; b < 8; b++) begin
            m[b*8 +: 8] = {8{s[b]}};
        end
        return m;
    endfunction

    function automatic void set_row(input int r, input logic is_write, input addr_t addr,
                                    input word_t wdata, input strb_t strb);
        rows[r]          = '0;
        rows[r].is_write = is_write;
        rows[r].addr     = addr;
        rows[r].wdata    = wdata;
        rows[r].strb     = strb;
    endfunction

    // fills the expected columns of one row and advances the model
    function automatic void predict_row(input int r);
        tag_t   tag;
        index_t idx;
        addr_t  line_addr;
        logic   w;
        tag       = rows[r].addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
        idx       = rows[r].addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
        line_addr = {rows[r].addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], offset_t'(0)};
        rows[r].exp_hit = 1'b1;
        if (m_valid[0][idx] && m_tag[0][idx] == tag) begin
            w = 1'b0;
        end else if (m_valid[1][idx] && m_tag[1][idx] == tag) begin
            w = 1'b1;
        end else begin
            rows[r].exp_hit = 1'b0;
            if (!m_valid[0][idx]) begin
                w = 1'b0;
            end else if (!m_valid[1][idx]) begin
                w = 1'b1;
            end else begin
                w = m_age[1][idx] > m_age[0][idx];
            end
            if (m_valid[w][idx] && m_dirty[w][idx]) begin
                rows[r].exp_wb      = 1'b1;
                rows[r].exp_wb_addr = {m_tag[w][idx], idx, offset_t'(0)};
                rows[r].exp_wb_data = m_data[w][idx];
                model_mem[rows[r].exp_wb_addr] = m_data[w][idx];
            end
            m_data[w][idx]  = model_mem.exists(line_addr) ? model_mem[line_addr]
                                                          : fill_value(line_addr);
            m_tag[w][idx]   = tag;
            m_valid[w][idx] = 1'b1;
            m_dirty[w][idx] = 1'b0;
        end
        if (rows[r].is_write) begin
            m_data[w][idx]  = (m_data[w][idx] & ~strb_mask(rows[r].strb))
                            | (rows[r].wdata & strb_mask(rows[r].strb));
            m_dirty[w][idx] = 1'b1;
        end
        rows[r].exp_rdata = rows[r].is_write ? '0 : m_data[w][idx];
        m_age[w][idx] = '0;
        if (m_age[~w][idx] != 3'(`DCACHE_AGE_MAX)) begin
            m_age[~w][idx] = m_age[~w][idx] + 3'd1;
        end
    endfunction

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        errors++;
        $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic apply_row(input int r);
        int    cycles;
        int    refills_before;
        int    wbs_before;
        int    errors_before;
        word_t got;
        refills_before = refill_count;
        wbs_before     = wb_count;
        errors_before  = errors;
        @(posedge clk);
        #2;
        req_valid_i = 1'b1;
        req_write_i = rows[r].is_write;
        req_addr_i  = rows[r].addr;
        req_wdata_i = rows[r].wdata;
        req_strb_i  = rows[r].strb;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!ready_o);
        got = rdata_o;
        #1;
        req_valid_i = 1'b0;
        if (got != rows[r].exp_rdata) report_mismatch("rdata_o", got, rows[r].exp_rdata);
        if (rows[r].exp_hit && cycles != 2) report_mismatch("hit latency", word_t'(cycles), 2);
        if (refill_count - refills_before != (rows[r].exp_hit ? 0 : 1)) begin
            report_mismatch("refill count", word_t'(refill_count - refills_before),
                            rows[r].exp_hit ? 0 : 1);
        end
        if (wb_count - wbs_before != (rows[r].exp_wb ? 1 : 0)) begin
            report_mismatch("write-back count", word_t'(wb_count - wbs_before),
                            rows[r].exp_wb ? 1 : 0);
        end
        if (!rows[r].exp_hit && last_refill_addr != {rows[r].addr[31:3], 3'b000}) begin
            report_mismatch("refill mem_addr_o", last_refill_addr, {rows[r].addr[31:3], 3'b000});
        end
        if (rows[r].exp_wb && last_wb_addr != rows[r].exp_wb_addr) begin
            report_mismatch("write-back mem_addr_o", last_wb_addr, rows[r].exp_wb_addr);
        end
        if (rows[r].exp_wb && last_wb_data != rows[r].exp_wb_data) begin
            report_mismatch("mem_wdata_o", last_wb_data, rows[r].exp_wb_data);
        end
        $display("row %0d %s addr %h in %0d cycles: %s", r, rows[r].is_write ? "write" : "read",
                 rows[r].addr, cycles, (errors == errors_before) ? "ok" : "failed");
    endtask

    // memory model giving one answer per request after 1 to 4 cycles
    initial begin : memory_model
        int wait_left;
        mem_ready_i  = 1'b0;
        mem_rdata_i  = '0;
        wb_count     = 0;
        refill_count = 0;
        wait_left    = 0;
        void'($urandom(32'h1cf1_4758));
        forever begin
            @(posedge clk);
            #2;
            mem_ready_i = 1'b0;
            mem_rdata_i = '0;
            if (!reset_i && mem_req_o != MEM_NONE) begin
                if (wait_left == 0) begin
                    wait_left = 1 + int'($urandom % 4);
                end
                wait_left--;
                if (wait_left == 0) begin
                    mem_ready_i = 1'b1;
                    if (mem_req_o == MEM_WRITEBACK) begin
                        bus_mem[mem_addr_o] = mem_wdata_o;
                        last_wb_addr = mem_addr_o;
                        last_wb_data = mem_wdata_o;
                        wb_count++;
                    end else begin
                        mem_rdata_i = bus_mem.exists(mem_addr_o) ? bus_mem[mem_addr_o]
                                                                 : fill_value(mem_addr_o);
                        last_refill_addr = mem_addr_o;
                        refill_count++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(NROWS * 40 * PERIOD);
        $display("Timeout: the cache did not finish the test rows in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin : stimulus
        errors      = 0;
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_strb_i  = '0;
        // set 5 sees tags 12, 345 and 70001; set 9 gets a write miss
        set_row(0, 1'b0, make_addr('h12, 5, 3), '0, '0);
        set_row(1, 1'b0, make_addr('h12, 5, 0), '0, '0);
        set_row(2, 1'b1, make_addr('h12, 5, 0), 64'h1122_3344_5566_7788, 8'h06);
        set_row(3, 1'b0, make_addr('h12, 5, 0), '0, '0);
        set_row(4, 1'b0, make_addr('h345, 5, 0), '0, '0);
        set_row(5, 1'b0, make_addr('h7_0001, 5, 0), '0, '0);
        set_row(6, 1'b0, make_addr('h12, 5, 0), '0, '0);
        set_row(7, 1'b0, make_addr('h7_0001, 5, 0), '0, '0);
        set_row(8, 1'b1, make_addr('h2A, 9, 0), 64'hDEAD_BEEF_0123_4567, 8'hF0);
        set_row(9, 1'b0, make_addr('h2A, 9, 0), '0, '0);
        set_row(10, 1'b0, make_addr('h12, 5, 0), '0, '0);
        for (int r = 0; r < NROWS; r++) begin
            predict_row(r);
        end
        repeat (5) @(posedge clk);
        #2;
        reset_i = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
            if (ready_o != 1'b0) report_mismatch("ready_o", word_t'(ready_o), '0);
            if (mem_req_o != MEM_NONE) begin
                report_mismatch("mem_req_o", word_t'(mem_req_o), word_t'(MEM_NONE));
            end
        end
        $display("idle after reset: %s", (errors == 0) ? "ok" : "failed");
        for (int r = 0; r < NROWS; r++) begin
            apply_row(r);
        end
        errors += dcache_top_i.dcache_ctrl_i.dcache_assertions_i.fail_count;
        $display("rows %0d, errors %0d, write-backs %0d, refills %0d",
                 NROWS, errors, wb_count, refill_count);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/dcache_assertions.sv
// Protocol checks on the cache controller, bound into dcache_ctrl.
// Checks are idle while reset_i is high.
`default_nettype none

module dcache_assertions import dcache_pkg::*; (
    input wire           clk,
    input wire           reset_i,
    input wire           ready_o,
    input wire mem_req_e mem_req_o,
    input wire addr_t    mem_addr_o,
    input wire word_t    mem_wdata_o,
    input wire           mem_ready_i
);

    int fail_count = 0;

    // a held memory request must not move until memory answers
    mem_req_held: assert property (@(posedge clk) disable iff (reset_i)
        (mem_req_o != MEM_NONE && !mem_ready_i)
            |=> ($stable(mem_req_o) && $stable(mem_addr_o) && $stable(mem_wdata_o)))
        else begin
            $error("memory request changed before mem_ready_i");
            fail_count++;
        end

    ready_single_cycle: assert property (@(posedge clk) disable iff (reset_i)
        ready_o |=> !ready_o)
        else begin
            $error("ready_o held for two cycles");
            fail_count++;
        end

    ready_not_with_mem: assert property (@(posedge clk) disable iff (reset_i)
        !(ready_o && (mem_req_o != MEM_NONE)))
        else begin
            $error("ready_o and a memory request in the same cycle");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: hdl/dcache_top.sv
// Two-way write-back data cache, 64 sets of one 64-bit word per way.
// Core requests are held until ready_o; memory answers with mem_ready_i.
// One request is in flight at a time.
`default_nettype none

`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
    input  wire          clk,
    input  wire          reset_i,
    input  wire          req_valid_i,
    input  wire          req_write_i,
    input  wire addr_t   req_addr_i,
    input  wire word_t   req_wdata_i,
    input  wire strb_t   req_strb_i,
    output logic         ready_o,
    output word_t        rdata_o,
    output mem_req_e     mem_req_o,
    output addr_t        mem_addr_o,
    output word_t        mem_wdata_o,
    input  wire          mem_ready_i,
    input  wire word_t   mem_rdata_i
);

    index_t array_index;
    index_t set_index;
    logic   tag_wr_en;
    logic   tag_wr_way;
    tag_t   tag_wr_tag;
    tag_t   tag0;
    tag_t   tag1;
    logic   valid0;
    logic   valid1;
    logic   touch;
    logic   touch_way;
    logic   set_dirty;
    logic   fill;
    logic   fill_way;
    logic   victim_way;
    logic   victim_dirty;
    logic   ram_wr_en;
    line_t  ram_wr_mask;
    line_t  ram_wr_data;
    line_t  ram_rd_data;

    dcache_ctrl dcache_ctrl_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_valid_i    (req_valid_i),
        .req_write_i    (req_write_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_strb_i     (req_strb_i),
        .ready_o        (ready_o),
        .rdata_o        (rdata_o),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_ready_i    (mem_ready_i),
        .mem_rdata_i    (mem_rdata_i),
        .array_index_o  (array_index),
        .set_index_o    (set_index),
        .tag_wr_en_o    (tag_wr_en),
        .tag_wr_way_o   (tag_wr_way),
        .tag_wr_tag_o   (tag_wr_tag),
        .tag0_i         (tag0),
        .tag1_i         (tag1),
        .valid0_i       (valid0),
        .valid1_i       (valid1),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .set_dirty_o    (set_dirty),
        .fill_o         (fill),
        .fill_way_o     (fill_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .ram_wr_en_o    (ram_wr_en),
        .ram_wr_mask_o  (ram_wr_mask),
        .ram_wr_data_o  (ram_wr_data),
        .ram_rd_data_i  (ram_rd_data)
    );

    dcache_tag_array dcache_tag_array_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .rd_index_i (array_index),
        .wr_index_i (set_index),
        .wr_way_i   (tag_wr_way),
        .wr_en_i    (tag_wr_en),
        .wr_tag_i   (tag_wr_tag),
        .tag0_o     (tag0),
        .tag1_o     (tag1),
        .valid0_o   (valid0),
        .valid1_o   (valid1)
    );

    dcache_line_state dcache_line_state_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .index_i        (set_index),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .set_dirty_i    (set_dirty),
        .fill_i         (fill),
        .fill_way_i     (fill_way),
        .valid0_i       (valid0),
        .valid1_i       (valid1),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

    dcache_data_ram dcache_data_ram_i (
        .clk       (clk),
        .index_i   (array_index),
        .wr_en_i   (ram_wr_en),
        .wr_mask_i (ram_wr_mask),
        .wr_data_i (ram_wr_data),
        .rd_data_o (ram_rd_data)
    );

endmodule

`default_nettype wire

// File: hdl/dcache_ctrl.sv
// Request FSM of the data cache for lookup, hit, write-back and refill.
// The core holds its request until ready_o; memory answers with a
// one-cycle mem_ready_i and the cache waits for it without a limit.
// Array reads are issued from IDLE so LOOKUP sees the addressed set.
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  wire          clk,
    input  wire          reset_i,
    input  wire          req_valid_i,
    input  wire          req_write_i,
    input  wire addr_t   req_addr_i,
    input  wire word_t   req_wdata_i,
    input  wire strb_t   req_strb_i,
    output logic         ready_o,
    output word_t        rdata_o,
    output mem_req_e     mem_req_o,
    output addr_t        mem_addr_o,
    output word_t        mem_wdata_o,
    input  wire          mem_ready_i,
    input  wire word_t   mem_rdata_i,
    output index_t       array_index_o,
    output index_t       set_index_o,
    output logic         tag_wr_en_o,
    output logic         tag_wr_way_o,
    output tag_t         tag_wr_tag_o,
    input  wire tag_t    tag0_i,
    input  wire tag_t    tag1_i,
    input  wire          valid0_i,
    input  wire          valid1_i,
    output logic         touch_o,
    output logic         touch_way_o,
    output logic         set_dirty_o,
    output logic         fill_o,
    output logic         fill_way_o,
    input  wire          victim_way_i,
    input  wire          victim_dirty_i,
    output logic         ram_wr_en_o,
    output line_t        ram_wr_mask_o,
    output line_t        ram_wr_data_o,
    input  wire line_t   ram_rd_data_i
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        write_q;
    addr_t       addr_q;
    word_t       wdata_q;
    strb_t       strb_q;
    logic        hit_way_q;
    logic        victim_way_q;
    tag_t        req_tag;
    index_t      req_index;
    logic        hit0;
    logic        hit1;
    tag_t        victim_tag;
    word_t       hit_word;
    word_t       victim_word;
    word_t       strb_bits;

    assign req_tag   = addr_q[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign req_index = addr_q[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];

    assign hit0 = valid0_i && (tag0_i == req_tag);
    assign hit1 = valid1_i && (tag1_i == req_tag);

    // request payload is taken when accepted
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_valid_i) begin
            write_q <= req_write_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            strb_q  <= req_strb_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= IDLE;
            hit_way_q    <= 1'b0;
            victim_way_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP) begin
                hit_way_q    <= hit1 & ~hit0;
                victim_way_q <= victim_way_i;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit0 || hit1) begin
                    state_d = HIT;
                end else if (victim_dirty_i) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            HIT: state_d = IDLE;
            WRITEBACK: begin
                if (mem_ready_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // back to LOOKUP which now hits
                if (mem_ready_i) begin
                    state_d = LOOKUP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // read the incoming set while idle
    assign array_index_o = (state_q == IDLE) ? req_addr_i[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W]
                                             : req_index;
    assign set_index_o   = req_index;

    assign hit_word    = hit_way_q ? ram_rd_data_i[2*`DCACHE_WORD_W-1:`DCACHE_WORD_W]
                                   : ram_rd_data_i[`DCACHE_WORD_W-1:0];
    assign victim_word = victim_way_q ? ram_rd_data_i[2*`DCACHE_WORD_W-1:`DCACHE_WORD_W]
                                      : ram_rd_data_i[`DCACHE_WORD_W-1:0];
    assign victim_tag  = victim_way_q ? tag1_i : tag0_i;

    assign ready_o = (state_q == HIT);
    assign rdata_o = (state_q == HIT && !write_q) ? hit_word : '0;

    always_comb begin
        mem_req_o   = MEM_NONE;
        mem_addr_o  = '0;
        mem_wdata_o = '0;
        if (state_q == WRITEBACK) begin
            mem_req_o   = MEM_WRITEBACK;
            mem_addr_o  = {victim_tag, req_index, {`DCACHE_OFFSET_W{1'b0}}};
            mem_wdata_o = victim_word;
        end else if (state_q == REFILL) begin
            mem_req_o  = MEM_REFILL;
            mem_addr_o = {req_tag, req_index, {`DCACHE_OFFSET_W{1'b0}}};
        end
    end

    always_comb begin
        for (int b = 0; b < `DCACHE_WORD_W/8; b++) begin
            strb_bits[b*8 +: 8] = {8{strb_q[b]}};
        end
    end

    // data is duplicated into both halves and the mask picks the way
    always_comb begin
        ram_wr_en_o   = 1'b0;
        ram_wr_mask_o = '0;
        ram_wr_data_o = {wdata_q, wdata_q};
        if (state_q == HIT && write_q) begin
            ram_wr_en_o   = 1'b1;
            ram_wr_mask_o = hit_way_q ? {strb_bits, word_t'(0)} : {word_t'(0), strb_bits};
        end else if (state_q == REFILL && mem_ready_i) begin
            ram_wr_en_o   = 1'b1;
            ram_wr_mask_o = victim_way_q ? {~word_t'(0), word_t'(0)}
                                         : {word_t'(0), ~word_t'(0)};
            ram_wr_data_o = {mem_rdata_i, mem_rdata_i};
        end
    end

    assign tag_wr_en_o  = (state_q == REFILL) && mem_ready_i;
    assign tag_wr_way_o = victim_way_q;
    assign tag_wr_tag_o = req_tag;

    assign touch_o     = (state_q == HIT);
    assign touch_way_o = hit_way_q;
    assign set_dirty_o = (state_q == HIT) && write_q;
    assign fill_o      = tag_wr_en_o;
    assign fill_way_o  = victim_way_q;

endmodule

`default_nettype wire

// File: hdl/dcache_data_ram.sv
// Single-port data RAM, one row per set, both ways side by side.
// Bit-masked write; the registered read returns the row after the write.
// Contents are undefined after reset.
`default_nettype none

`include "dcache_settings.svh"

module dcache_data_ram import dcache_pkg::*; (
    input  wire          clk,
    input  wire index_t  index_i,
    input  wire          wr_en_i,
    input  wire line_t   wr_mask_i,
    input  wire line_t   wr_data_i,
    output line_t        rd_data_o
);

    line_t mem [`DCACHE_SETS];
    line_t merged;

    // untouched bits keep the old row
    assign merged = (mem[index_i] & ~wr_mask_i) | (wr_data_i & wr_mask_i);

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[index_i] <= merged;
            rd_data_o    <= merged;
        end else begin
            rd_data_o    <= mem[index_i];
        end
    end

endmodule

`default_nettype wire

// File: hdl/dcache_line_state.sv
// Dirty bits and age counters per set and way, and the victim choice.
// The valid bits come from the tag array and must belong to index_i.
// The victim is the first invalid way, else the older way, way 0 on a tie.
`default_nettype none

`include "dcache_settings.svh"

module dcache_line_state import dcache_pkg::*; (
    input  wire          clk,
    input  wire          reset_i,
    input  wire index_t  index_i,
    input  wire          touch_i,
    input  wire          touch_way_i,
    input  wire          set_dirty_i,
    input  wire          fill_i,
    input  wire          fill_way_i,
    input  wire          valid0_i,
    input  wire          valid1_i,
    output logic         victim_way_o,
    output logic         victim_dirty_o
);

    logic [2:0]              age_q [2][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0] dirty_q [2];
    logic                    other_way;
    logic [2:0]              other_age;

    assign other_way = ~touch_way_i;
    assign other_age = age_q[other_way][index_i];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                age_q[0][s] <= '0;
                age_q[1][s] <= '0;
            end
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
        end else begin
            if (touch_i) begin
                age_q[touch_way_i][index_i] <= '0;
                // other way of the same set gets older
                if (other_age != 3'(`DCACHE_AGE_MAX)) begin
                    age_q[other_way][index_i] <= other_age + 3'd1;
                end
                if (set_dirty_i) begin
                    dirty_q[touch_way_i][index_i] <= 1'b1;
                end
            end
            if (fill_i) begin
                dirty_q[fill_way_i][index_i] <= 1'b0;
            end
        end
    end

    always_comb begin
        if (!valid0_i) begin
            victim_way_o = 1'b0;
        end else if (!valid1_i) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = age_q[1][index_i] > age_q[0][index_i];
        end
    end

    assign victim_dirty_o = victim_way_o ? (dirty_q[1][index_i] & valid1_i)
                                         : (dirty_q[0][index_i] & valid0_i);

endmodule

`default_nettype wire

// File: hdl/dcache_tag_array.sv
// Tags and valid bits for both ways.
// Read data appears one cycle after rd_index_i. A write to the index
// being read is forwarded, so the next cycle already sees the new tag.
// Valid bits clear on reset and are never cleared otherwise.
`default_nettype none

`include "dcache_settings.svh"

module dcache_tag_array import dcache_pkg::*; (
    input  wire          clk,
    input  wire          reset_i,
    input  wire index_t  rd_index_i,
    input  wire index_t  wr_index_i,
    input  wire          wr_way_i,
    input  wire          wr_en_i,
    input  wire tag_t    wr_tag_i,
    output tag_t         tag0_o,
    output tag_t         tag1_o,
    output logic         valid0_o,
    output logic         valid1_o
);

    tag_t                    tag_mem [2][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0] valid_q [2];
    tag_t                    tag_rd_q [2];
    logic [1:0]              valid_rd_q;
    logic [1:0]              fwd;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            fwd[w] = wr_en_i && (wr_way_i == 1'(w)) && (wr_index_i == rd_index_i);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_way_i][wr_index_i] <= wr_tag_i;
        end
        for (int w = 0; w < 2; w++) begin
            tag_rd_q[w] <= fwd[w] ? wr_tag_i : tag_mem[w][rd_index_i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            valid_rd_q <= '0;
        end else begin
            if (wr_en_i) begin
                valid_q[wr_way_i][wr_index_i] <= 1'b1;
            end
            for (int w = 0; w < 2; w++) begin
                valid_rd_q[w] <= fwd[w] | valid_q[w][rd_index_i];
            end
        end
    end

    assign tag0_o   = tag_rd_q[0];
    assign tag1_o   = tag_rd_q[1];
    assign valid0_o = valid_rd_q[0];
    assign valid1_o = valid_rd_q[1];

endmodule

`default_nettype wire

// File: hdl/dcache_pkg.sv
// Types shared by the data cache blocks.
// A RAM line holds way 0 in the low half and way 1 in the high half.
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0]     addr_t;
    typedef logic [`DCACHE_TAG_W-1:0]      tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]    index_t;
    typedef logic [`DCACHE_WORD_W-1:0]     word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0]   strb_t;
    typedef logic [2*`DCACHE_WORD_W-1:0]   line_t;

    typedef enum logic [1:0] {
        MEM_NONE      = 2'd0,
        MEM_WRITEBACK = 2'd1,
        MEM_REFILL    = 2'd2
    } mem_req_e;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        HIT       = 3'd2,
        WRITEBACK = 3'd3,
        REFILL    = 3'd4
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: include/dcache_settings.svh
// Geometry of the two-way data cache.
// Address split is tag 31..9, index 8..3, byte offset 2..0.
// Tag, index and offset widths must add up to the address width.
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address split
`define DCACHE_ADDR_W   32
`define DCACHE_TAG_W    23
`define DCACHE_INDEX_W  6
`define DCACHE_OFFSET_W 3

// one word per way per set
`define DCACHE_WORD_W   64
`define DCACHE_SETS     64

// age counters saturate here
`define DCACHE_AGE_MAX  7

`endif
